//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fpMulTb
FILELIST  = fpMul.f
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) src/fpMul_defines.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^=== PASS ===$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- fpMul.f
+incdir+src
src/fpMulPkg.sv
src/leafMult.sv
src/subRecursiveKOA.sv
src/operandUnpack.sv
src/normRound.sv
src/mulControl.sv
src/fpMulTop.sv
verification/fpMul_assert.sv
verification/fpMulTb.sv

//--- src/fpMulPkg.sv
// Control FSM states and operand classes for the binary32 multiplier, denormals are counted as zero
package fpMulPkg;

    // ================================================
    // Control FSM states
    // ================================================

    // One operation in flight at a time
    // IDLE waits for start, DONE holds for exactly one cycle
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_MULT  = 2'd1,
        ST_ROUND = 2'd2,
        ST_DONE  = 2'd3
    } ctrlState_t;

    // ================================================
    // Operand classes
    // ================================================

    // Denormals are flushed and land in CLS_ZERO
    // CLS_NAN covers quiet and signalling encodings alike
    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0,
        CLS_NORMAL = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } fpClass_t;

endpackage

//--- src/fpMulTop.sv
// Binary32 multiplier top, three cycles from start to done, no denormals and round to nearest even only
`timescale 1ns/1ps
`include "fpMul_defines.svh"

module fpMulTop import fpMulPkg::*; (
    input  logic        clk,
    input  logic        rstN_i,
    input  logic        start_i,
    input  logic [31:0] opA_i,
    input  logic [31:0] opB_i,
    output logic [31:0] result_o,
    output logic        busy_o,
    output logic        done_o
);

    // Control strobes
    logic loadOps;
    logic loadRes;

    // Unpacked operand fields
    logic                   signA;
    logic                   signB;
    logic [`FP_EXP_W-1:0]   expA;
    logic [`FP_EXP_W-1:0]   expB;
    logic [`FP_SIG_W-1:0]   sigA;
    logic [`FP_SIG_W-1:0]   sigB;
    fpClass_t               clsA;
    fpClass_t               clsB;
    // Full significand product
    logic [2*`FP_SIG_W-1:0] sigProd;

    // ================================================
    // Control
    // ================================================
    mulControl i_mulControl (
        .clk       (clk),
        .rstN_i    (rstN_i),
        .start_i   (start_i),
        .loadOps_o (loadOps),
        .loadRes_o (loadRes),
        .busy_o    (busy_o),
        .done_o    (done_o)
    );

    // ================================================
    // Datapath
    // ================================================
    operandUnpack i_operandUnpack (
        .clk       (clk),
        .rstN_i    (rstN_i),
        .loadOps_i (loadOps),
        .opA_i     (opA_i),
        .opB_i     (opB_i),
        .signA_o   (signA),
        .signB_o   (signB),
        .expA_o    (expA),
        .expB_o    (expB),
        .sigA_o    (sigA),
        .sigB_o    (sigB),
        .clsA_o    (clsA),
        .clsB_o    (clsB)
    );

    // Operand registers hold steady so the leaves need no enable
    subRecursiveKOA #(.SW(`FP_SIG_W)) i_subRecursiveKOA (
        .clk     (clk),
        .dataA_i (sigA),
        .dataB_i (sigB),
        .dataS_o (sigProd)
    );

    normRound i_normRound (
        .clk       (clk),
        .rstN_i    (rstN_i),
        .loadRes_i (loadRes),
        .signA_i   (signA),
        .signB_i   (signB),
        .expA_i    (expA),
        .expB_i    (expB),
        .clsA_i    (clsA),
        .clsB_i    (clsB),
        .prod_i    (sigProd),
        .result_o  (result_o)
    );

endmodule

//--- src/fpMul_defines.svh
// Binary32 format constants and the KOA leaf width, which must stay at or above 13 for a 24-bit split
`ifndef FPMUL_DEFINES_SVH
`define FPMUL_DEFINES_SVH

// Exponent field width
`define FP_EXP_W   8
// Stored fraction width
`define FP_MAN_W   23
// Significand width including the hidden bit
`define FP_SIG_W   24
// Exponent bias
`define FP_BIAS    127

// Widest operand one leaf multiplier takes
`define KOA_LEAF_W 16

// Canonical quiet NaN with positive sign and no payload
`define FP_QNAN    32'h7FC0_0000

`endif

//--- src/leafMult.sv
// Registered base-case multiplier with no reset and no enable, so inputs must be stable for one edge
`timescale 1ns/1ps

module leafMult #(
    parameter int SW = 16
) (
    input  logic            clk,
    input  logic [SW-1:0]   a_i,
    input  logic [SW-1:0]   b_i,
    output logic [2*SW-1:0] prod_o
);

    // ================================================
    // Leaf product
    // ================================================

    // Full width product before the register
    logic [2*SW-1:0] prodComb;

    // Operands widened to the product width
    assign prodComb = {{SW{1'b0}}, a_i} * {{SW{1'b0}}, b_i};

    // Product register
    // Sets the single cycle of KOA latency
    always_ff @(posedge clk) begin
        prod_o <= prodComb;
    end

endmodule

//--- src/mulControl.sv
// Control FSM for one operation at a time with no queue, start is dropped while busy is high
`timescale 1ns/1ps

module mulControl import fpMulPkg::*; (
    input  logic clk,
    input  logic rstN_i,
    input  logic start_i,
    output logic loadOps_o,
    output logic loadRes_o,
    output logic busy_o,
    output logic done_o
);

    ctrlState_t curState;
    ctrlState_t nextState;

    // ================================================
    // State register
    // ================================================
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i)
            curState <= ST_IDLE;
        else
            curState <= nextState;
    end

    // Fixed walk through the datapath stages
    always_comb begin
        nextState = curState;
        case (curState)
            ST_IDLE: begin
                if (start_i)
                    nextState = ST_MULT;
            end
            // Leaf products register here
            ST_MULT:  nextState = ST_ROUND;
            // Packed result registers here
            ST_ROUND: nextState = ST_DONE;
            ST_DONE:  nextState = ST_IDLE;
            default:  nextState = ST_IDLE;
        endcase
    end

    // ================================================
    // Strobes and status
    // ================================================
    // Operand capture on the same edge that samples start
    assign loadOps_o = (curState == ST_IDLE) && start_i;
    assign loadRes_o = (curState == ST_ROUND);
    // Busy covers every state after the start edge
    assign busy_o    = (curState != ST_IDLE);
    // Single cycle done pulse
    assign done_o    = (curState == ST_DONE);

endmodule

//--- src/normRound.sv
// Normalize and round to nearest even, results below the normal range flush to signed zero
`timescale 1ns/1ps
`include "fpMul_defines.svh"

module normRound import fpMulPkg::*; (
    input  logic                   clk,
    input  logic                   rstN_i,
    input  logic                   loadRes_i,
    input  logic                   signA_i,
    input  logic                   signB_i,
    input  logic [`FP_EXP_W-1:0]   expA_i,
    input  logic [`FP_EXP_W-1:0]   expB_i,
    input  fpClass_t               clsA_i,
    input  fpClass_t               clsB_i,
    input  logic [2*`FP_SIG_W-1:0] prod_i,
    output logic [31:0]            result_o
);

    localparam int PW = 2 * `FP_SIG_W;
    localparam int EW = `FP_EXP_W + 2;

    logic                 resSign;
    logic signed [EW:0]   expSum;
    logic signed [EW:0]   expAdj;
    logic signed [EW:0]   finalExp;
    logic [PW-1:0]        normProd;
    logic                 guardBit;
    logic                 stickyBit;
    logic                 roundUp;
    logic [`FP_SIG_W:0]   rounded;
    logic [`FP_MAN_W-1:0] finalMan;
    logic                 isNan;
    logic                 isInf;
    logic                 isZero;
    logic [31:0]          nextRes;

    // ================================================
    // Sign and exponent
    // ================================================
    assign resSign = signA_i ^ signB_i;
    // Signed so underflow shows as a negative value
    assign expSum = $signed({3'b000, expA_i}) + $signed({3'b000, expB_i}) - `FP_BIAS;

    // ================================================
    // Normalize and round
    // ================================================
    // Product lies in [1,4), leading one at bit 47 or 46
    assign normProd  = prod_i[PW-1] ? prod_i : (prod_i << 1);
    assign guardBit  = normProd[PW-`FP_SIG_W-1];
    assign stickyBit = |normProd[PW-`FP_SIG_W-2:0];
    // Ties go to the even neighbour
    assign roundUp   = guardBit & (stickyBit | normProd[PW-`FP_SIG_W]);
    assign rounded   = {1'b0, normProd[PW-1 -: `FP_SIG_W]} + {{`FP_SIG_W{1'b0}}, roundUp};
    // Carry out only from all ones, so the fraction becomes zero
    assign finalMan  = rounded[`FP_SIG_W] ? rounded[`FP_SIG_W-1:1] : rounded[`FP_MAN_W-1:0];

    // One per normalize step and rounding carry
    assign expAdj   = {{EW{1'b0}}, prod_i[PW-1]} + {{EW{1'b0}}, rounded[`FP_SIG_W]};
    assign finalExp = expSum + expAdj;

    // ================================================
    // Special cases and packing
    // ================================================
    assign isNan  = (clsA_i == CLS_NAN) || (clsB_i == CLS_NAN) ||
                    ((clsA_i == CLS_INF) && (clsB_i == CLS_ZERO)) ||
                    ((clsA_i == CLS_ZERO) && (clsB_i == CLS_INF));
    assign isInf  = (clsA_i == CLS_INF) || (clsB_i == CLS_INF);
    assign isZero = (clsA_i == CLS_ZERO) || (clsB_i == CLS_ZERO);

    // Priority follows NaN, Inf, zero, overflow, underflow
    always_comb begin
        if (isNan)
            nextRes = `FP_QNAN;
        else if (isInf || (finalExp >= 255))
            nextRes = {resSign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
        else if (isZero || (finalExp < 1))
            nextRes = {resSign, 31'd0};
        else
            nextRes = {resSign, finalExp[`FP_EXP_W-1:0], finalMan};
    end

    // Result holds until the next round strobe
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i)
            result_o <= '0;
        else if (loadRes_i)
            result_o <= nextRes;
    end

endmodule

//--- src/operandUnpack.sv
// Operand capture and classification with denormals flushed to zero and NaN payloads ignored
`timescale 1ns/1ps
`include "fpMul_defines.svh"

module operandUnpack import fpMulPkg::*; (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  logic                 loadOps_i,
    input  logic [31:0]          opA_i,
    input  logic [31:0]          opB_i,
    output logic                 signA_o,
    output logic                 signB_o,
    output logic [`FP_EXP_W-1:0] expA_o,
    output logic [`FP_EXP_W-1:0] expB_o,
    output logic [`FP_SIG_W-1:0] sigA_o,
    output logic [`FP_SIG_W-1:0] sigB_o,
    output fpClass_t             clsA_o,
    output fpClass_t             clsB_o
);

    // Exponent 0 is zero, all ones is Inf or NaN by the fraction
    function automatic fpClass_t classify(input logic [31:0] op);
        logic [`FP_EXP_W-1:0] e;
        logic [`FP_MAN_W-1:0] f;
        e = op[30 -: `FP_EXP_W];
        f = op[`FP_MAN_W-1:0];
        if (e == '0)
            return CLS_ZERO;
        else if (e == '1)
            return (f == '0) ? CLS_INF : CLS_NAN;
        else
            return CLS_NORMAL;
    endfunction

    // Class registers, cleared so a stray round sees zeros
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            clsA_o <= CLS_ZERO;
            clsB_o <= CLS_ZERO;
        end else if (loadOps_i) begin
            clsA_o <= classify(opA_i);
            clsB_o <= classify(opB_i);
        end
    end

    // Field registers
    // Hidden bit only for a nonzero exponent
    always_ff @(posedge clk) begin
        if (loadOps_i) begin
            signA_o <= opA_i[31];
            signB_o <= opB_i[31];
            expA_o  <= opA_i[30 -: `FP_EXP_W];
            expB_o  <= opB_i[30 -: `FP_EXP_W];
            sigA_o  <= {|opA_i[30 -: `FP_EXP_W], opA_i[`FP_MAN_W-1:0]};
            sigB_o  <= {|opB_i[30 -: `FP_EXP_W], opB_i[`FP_MAN_W-1:0]};
        end
    end

endmodule

//--- src/subRecursiveKOA.sv
// Recursive Karatsuba-Ofman multiplier with one cycle latency from the leaf registers, combine is combinational
`timescale 1ns/1ps
`include "fpMul_defines.svh"

module subRecursiveKOA #(
    parameter int SW = 24
) (
    input  logic            clk,
    input  logic [SW-1:0]   dataA_i,
    input  logic [SW-1:0]   dataB_i,
    output logic [2*SW-1:0] dataS_o
);

    generate
        if (SW <= `KOA_LEAF_W) begin : genLeaf
            // Small enough for one multiplier
            leafMult #(.SW(SW)) i_leafMult (
                .clk    (clk),
                .a_i    (dataA_i),
                .b_i    (dataB_i),
                .prod_o (dataS_o)
            );
        end else begin : genSplit
            case (SW % 2)
                0: begin : genEven
                    // ================================================
                    // Even split with equal halves
                    // ================================================
                    localparam int HW = SW / 2;
                    logic [HW:0]     sumA;
                    logic [HW:0]     sumB;
                    logic [2*HW-1:0] qLeft;
                    logic [2*HW-1:0] qRight;
                    logic [2*HW+1:0] qMiddle;
                    logic [2*HW+1:0] crossTerm;

                    // Half sums carry one extra bit
                    assign sumA = {1'b0, dataA_i[SW-1:HW]} + {1'b0, dataA_i[HW-1:0]};
                    assign sumB = {1'b0, dataB_i[SW-1:HW]} + {1'b0, dataB_i[HW-1:0]};

                    subRecursiveKOA #(.SW(HW)) i_left (
                        .clk     (clk),
                        .dataA_i (dataA_i[SW-1:HW]),
                        .dataB_i (dataB_i[SW-1:HW]),
                        .dataS_o (qLeft)
                    );
                    subRecursiveKOA #(.SW(HW)) i_right (
                        .clk     (clk),
                        .dataA_i (dataA_i[HW-1:0]),
                        .dataB_i (dataB_i[HW-1:0]),
                        .dataS_o (qRight)
                    );
                    subRecursiveKOA #(.SW(HW+1)) i_middle (
                        .clk     (clk),
                        .dataA_i (sumA),
                        .dataB_i (sumB),
                        .dataS_o (qMiddle)
                    );

                    // Cross products aH*bL + aL*bH
                    assign crossTerm = qMiddle - qLeft - qRight;
                    // Left sits at 2*HW, so concatenation places it
                    assign dataS_o = {qLeft, qRight} + ({{(SW-2){1'b0}}, crossTerm} << HW);
                end
                default: begin : genOdd
                    // ================================================
                    // Odd split with the low half one bit wider
                    // ================================================
                    localparam int HW = SW / 2;
                    localparam int LW = HW + 1;
                    logic [LW:0]     sumA;
                    logic [LW:0]     sumB;
                    logic [2*HW-1:0] qLeft;
                    logic [2*LW-1:0] qRight;
                    logic [2*LW+1:0] qMiddle;
                    logic [2*LW+1:0] crossTerm;

                    // High half zero-extended to the low width
                    assign sumA = {2'b00, dataA_i[SW-1:LW]} + {1'b0, dataA_i[LW-1:0]};
                    assign sumB = {2'b00, dataB_i[SW-1:LW]} + {1'b0, dataB_i[LW-1:0]};

                    subRecursiveKOA #(.SW(HW)) i_left (
                        .clk     (clk),
                        .dataA_i (dataA_i[SW-1:LW]),
                        .dataB_i (dataB_i[SW-1:LW]),
                        .dataS_o (qLeft)
                    );
                    subRecursiveKOA #(.SW(LW)) i_right (
                        .clk     (clk),
                        .dataA_i (dataA_i[LW-1:0]),
                        .dataB_i (dataB_i[LW-1:0]),
                        .dataS_o (qRight)
                    );
                    subRecursiveKOA #(.SW(LW+1)) i_middle (
                        .clk     (clk),
                        .dataA_i (sumA),
                        .dataB_i (sumB),
                        .dataS_o (qMiddle)
                    );

                    assign crossTerm = qMiddle - qLeft - qRight;
                    assign dataS_o = {qLeft, qRight} + ({{(SW-3){1'b0}}, crossTerm} << LW);
                end
            endcase
        end
    endgenerate

endmodule

//--- verification/fpMulTb.sv
// Self-checking testbench with a model that flushes denormals and rounds to nearest even only
`timescale 1ns/1ps
`include "fpMul_defines.svh"

module fpMulTb;

    // About 620 operations at up to 6 cycles each, with margin
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int DONE_WAIT_MAX  = 20;
    localparam int RANDOM_OPS     = 600;

    logic        clk;
    logic        rstN;
    logic        start;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] result;
    logic        busy;
    logic        done;

    // Pending operations, oldest first
    logic [31:0] expQ[$];
    logic [31:0] opAQ[$];
    logic [31:0] opBQ[$];
    logic [31:0] expRes;
    logic [31:0] chkA;
    logic [31:0] chkB;
    logic [31:0] lfsrState;
    int checkCount = 0;
    int errCount   = 0;
    int doneCount  = 0;
    int cycleCount = 0;
    int chkBase    = 0;
    int errBase    = 0;

    fpMulTop i_fpMulTop (
        .clk      (clk),
        .rstN_i   (rstN),
        .start_i  (start),
        .opA_i    (opA),
        .opB_i    (opB),
        .result_o (result),
        .busy_o   (busy),
        .done_o   (done)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // ==================================================
    // Reference model
    // ==================================================
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    // Expected product from the format rules
    function automatic logic [31:0] refMul(input logic [31:0] a, input logic [31:0] b);
        int     ea;
        int     eb;
        int     rExp;
        int     sh;
        longint prod;
        longint mant;
        longint rem;
        longint half;
        logic   rSign;
        logic   aZero;
        logic   bZero;
        logic   aInf;
        logic   bInf;
        logic   aNan;
        logic   bNan;
        ea    = a[30:23];
        eb    = b[30:23];
        rSign = a[31] ^ b[31];
        // Denormal inputs count as zero
        aZero = (ea == 0);
        bZero = (eb == 0);
        aInf  = (ea == 255) && (a[22:0] == 0);
        bInf  = (eb == 255) && (b[22:0] == 0);
        aNan  = (ea == 255) && (a[22:0] != 0);
        bNan  = (eb == 255) && (b[22:0] != 0);
        if (aNan || bNan || (aInf && bZero) || (aZero && bInf))
            return `FP_QNAN;
        if (aInf || bInf)
            return {rSign, 8'hFF, 23'd0};
        if (aZero || bZero)
            return {rSign, 31'd0};
        prod = longint'({1'b1, a[22:0]}) * longint'({1'b1, b[22:0]});
        rExp = ea + eb - `FP_BIAS;
        // Keep 24 significant bits, the rest is the remainder
        if (prod >= (64'sd1 << 47)) begin
            sh = 24;
            rExp++;
        end else begin
            sh = 23;
        end
        mant = prod >> sh;
        rem  = prod - (mant << sh);
        half = 64'sd1 << (sh - 1);
        // Above half rounds up, exact half goes to even
        if ((rem > half) || ((rem == half) && mant[0]))
            mant++;
        if (mant == (64'sd1 << 24)) begin
            mant = mant >> 1;
            rExp++;
        end
        if (rExp >= 255)
            return {rSign, 8'hFF, 23'd0};
        if (rExp < 1)
            return {rSign, 31'd0};
        return {rSign, rExp[7:0], mant[22:0]};
    endfunction

    // ==================================================
    // Stimulus helpers
    // ==================================================
    // Returns just after the edge that samples start
    task automatic issueOp(input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        opA   <= a;
        opB   <= b;
        start <= 1'b1;
        expQ.push_back(refMul(a, b));
        opAQ.push_back(a);
        opBQ.push_back(b);
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Counts falling edges until done, bounded
    task automatic waitDone(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && (cycles < DONE_WAIT_MAX));
        if (!done) begin
            $display("ERROR: done_o did not arrive within %0d cycles at %0t ns",
                     DONE_WAIT_MAX, $time);
            errCount++;
        end
    endtask

    task automatic runOp(input logic [31:0] a, input logic [31:0] b);
        int lat;
        issueOp(a, b);
        waitDone(lat);
    endtask

    // Random normal operand, exponent kept in 64..191
    task automatic randNormal(output logic [31:0] op);
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] f;
        logic [7:0]  ex;
        takeBits(1, s);
        takeBits(7, e);
        takeBits(23, f);
        ex = {1'b0, e[6:0]} + 8'd64;
        op = {s[0], ex, f[22:0]};
    endtask

    // Lets the compare process settle first
    task automatic reportTest(input string name);
        @(posedge clk);
        $display("Test %-20s checks %0d  errors %0d", name, checkCount - chkBase,
                 errCount - errBase);
        chkBase = checkCount;
        errBase = errCount;
    endtask

    // ==================================================
    // Compare and watchdog
    // ==================================================
    // Mid-cycle sampling of done and result
    always @(negedge clk) begin : compare
        if (rstN && done) begin
            doneCount++;
            if (expQ.size() == 0) begin
                $display("ERROR: done_o pulsed at %0t ns with no operation pending", $time);
                errCount++;
            end else begin
                expRes = expQ.pop_front();
                chkA   = opAQ.pop_front();
                chkB   = opBQ.pop_front();
                checkCount++;
                if (result !== expRes) begin
                    $display("[FAIL] %0t ns: opA=%h opB=%h result=%h expected=%h",
                             $time, chkA, chkB, result, expRes);
                    errCount++;
                end
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : stimulus
        int          lat;
        logic [31:0] a;
        logic [31:0] b;
        clk       = 1'b0;
        rstN      = 1'b0;
        start     = 1'b0;
        opA       = '0;
        opB       = '0;
        lfsrState = 32'h01a5_58bc;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        // Reset values, then start to done latency
        @(negedge clk);
        checkCount++;
        if ((busy !== 1'b0) || (done !== 1'b0) || (result !== 32'd0)) begin
            $display("[FAIL] %0t ns: after reset busy=%b done=%b result=%h",
                     $time, busy, done, result);
            errCount++;
        end
        issueOp(32'h3FC0_0000, 32'h4000_0000);
        waitDone(lat);
        checkCount++;
        if (lat != 3) begin
            $display("[FAIL] %0t ns: done_o after %0d cycles, expected 3", $time, lat);
            errCount++;
        end
        @(negedge clk);
        checkCount++;
        if (done !== 1'b0) begin
            $display("[FAIL] %0t ns: done_o high for more than one cycle", $time);
            errCount++;
        end
        reportTest("reset and latency");

        // Exact, tie up, tie down, rounding carry
        runOp(32'h3FC0_0000, 32'h4000_0000);
        runOp(32'h3F80_0001, 32'h3FC0_0000);
        runOp(32'h3F80_0003, 32'h3FC0_0000);
        runOp(32'h3F80_0001, 32'h3F7F_FFFE);
        runOp(32'hC049_0FDB, 32'h3F00_0000);
        runOp(32'h3FFF_FFFF, 32'hBFFF_FFFF);
        reportTest("directed normals");

        for (int i = 0; i < RANDOM_OPS; i++) begin
            randNormal(a);
            randNormal(b);
            runOp(a, b);
        end
        reportTest("random normals");

        // NaN, Inf times zero, Inf and zero operands
        runOp(32'h7FC0_0000, 32'h3F80_0000);
        runOp(32'h3F80_0000, 32'hFF80_0001);
        runOp(32'h7F80_0000, 32'h0000_0000);
        runOp(32'h8000_0000, 32'hFF80_0000);
        runOp(32'h7F80_0000, 32'hC000_0000);
        runOp(32'h8000_0000, 32'h4040_0000);
        reportTest("special operands");

        // Overflow, underflow, denormal inputs
        runOp(32'h7F00_0000, 32'h4000_0000);
        runOp(32'hFF7F_FFFF, 32'h7F7F_FFFF);
        runOp(32'h0080_0000, 32'h3F00_0000);
        runOp(32'h0000_0001, 32'h3F80_0000);
        runOp(32'h8040_0000, 32'h4000_0000);
        reportTest("exponent extremes");

        // Second start lands in ST_ROUND and must be dropped
        a = doneCount;
        issueOp(32'h4040_0000, 32'h40A0_0000);
        @(negedge clk);
        checkCount++;
        if (busy !== 1'b1) begin
            $display("[FAIL] %0t ns: busy_o low while an operation is in flight", $time);
            errCount++;
        end
        @(posedge clk);
        opA   <= 32'h4100_0000;
        opB   <= 32'h4110_0000;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        waitDone(lat);
        repeat (6) @(negedge clk);
        checkCount++;
        if (doneCount - a != 1) begin
            $display("[FAIL] %0t ns: %0d done pulses, expected 1", $time, doneCount - a);
            errCount++;
        end
        reportTest("start while busy");

        $display("Total checks %0d  errors %0d  done pulses %0d", checkCount, errCount,
                 doneCount);
        if ((errCount == 0) && (expQ.size() == 0))
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verification/fpMul_assert.sv
// Control protocol assertions bound into the FSM, checked only while reset is released
`timescale 1ns/1ps

module fpMulAssert import fpMulPkg::*; (
    input logic       clk,
    input logic       rstN_i,
    input logic       loadOps_i,
    input logic       busy_i,
    input logic       done_i,
    input ctrlState_t state_i
);

    // ==================================================
    // Strobe timing
    // ==================================================
    // Done is a single cycle pulse
    doneOnePulse: assert property (@(posedge clk) disable iff (!rstN_i)
        done_i |=> !done_i)
        else $error("done_o held for more than one cycle");

    // Capture cycle, MULT, ROUND, then DONE
    doneAfterLoad: assert property (@(posedge clk) disable iff (!rstN_i)
        loadOps_i |-> ##3 done_i)
        else $error("done_o did not follow loadOps_o after 3 cycles");

    // ==================================================
    // Busy rules
    // ==================================================
    // No second capture while the operation is in flight
    noLoadWhileBusy: assert property (@(posedge clk) disable iff (!rstN_i)
        loadOps_i |=> !loadOps_i ##1 !loadOps_i ##1 !loadOps_i)
        else $error("loadOps_o raised while busy_o is high");

    // Busy spans MULT, ROUND and DONE, then back to IDLE
    busyDuringOp: assert property (@(posedge clk) disable iff (!rstN_i)
        loadOps_i |=> busy_i ##1 busy_i ##1 busy_i ##1 (!busy_i && (state_i == ST_IDLE)))
        else $error("busy_o did not cover exactly the three cycles of an operation");

endmodule

bind mulControl fpMulAssert i_fpMulAssert (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .loadOps_i (loadOps_o),
    .busy_i    (busy_o),
    .done_i    (done_o),
    .state_i   (curState)
);
